/* Makefile */
TOP = branch_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

/* hw/branch_consts.svh */
`ifndef BRANCH_CONSTS_SVH
`define BRANCH_CONSTS_SVH

// branches in flight, sizes both queues
`define BR_ENTRIES 4
`define BR_IDX_WIDTH $clog2(`BR_ENTRIES)
`define BR_CNT_WIDTH ($clog2(`BR_ENTRIES) + 1)

// saved stack slots
`define BR_BACKUPS 4
`define BK_IDX_WIDTH $clog2(`BR_BACKUPS)
`define BK_CNT_WIDTH ($clog2(`BR_BACKUPS) + 1)

`define ROB_WIDTH 5
`define ADDR_WIDTH 16
`define STACK_WIDTH 3  // 8 return slots
`define DATA_WIDTH 32

`endif

/* hw/branch_pkg.sv */
`include "branch_consts.svh"

package branch_pkg;

	typedef enum logic [1:0] {
		CMP_FZ,   // float exponent field zero
		CMP_FLE,
		CMP_E,
		CMP_LE    // signed
	} cmp_type_t;

	// one in-flight branch, oldest at index 0
	typedef struct packed {
		logic resolved;
		logic failure;
		logic [1:0] prediction;
		logic [`ADDR_WIDTH-1:0] addr_on_failure;
		logic [`STACK_WIDTH-1:0] stack_pointer;  // return stack pointer at issue
		logic [`ROB_WIDTH-1:0] gpr_tag;
		logic [`ROB_WIDTH-1:0] fpr_tag;
	} branch_entry_t;

	// integer compares read the gpr side
	function automatic logic is_int_cmp(cmp_type_t t);
		return t == CMP_E || t == CMP_LE;
	endfunction

endpackage

/* hw/branch_queue.sv */
`timescale 1ns/1ps
`include "branch_consts.svh"

module branch_queue (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input logic [1:0] prediction,
	input logic [`ADDR_WIDTH-1:0] addr_on_failure,
	input logic [`ROB_WIDTH-1:0] gpr_issue_tag,
	input logic [`ROB_WIDTH-1:0] fpr_issue_tag,
	input logic [`ROB_WIDTH-1:0] gpr_commit_tag,
	input logic [`ROB_WIDTH-1:0] fpr_commit_tag,
	input logic [`STACK_WIDTH-1:0] stack_pointer,
	input logic resolve,
	input logic taken,
	output logic issue_ready,
	output logic issue_fire,
	output logic commit,
	output logic flush,
	output logic failure,
	output logic [1:0] prediction_end,
	output logic [`ADDR_WIDTH-1:0] addr_on_failure_out,
	output logic [`STACK_WIDTH-1:0] head_stack_pointer,
	output logic [`BR_CNT_WIDTH-1:0] count_after_commit,
	output logic speculating
);
	branch_pkg::branch_entry_t e [`BR_ENTRIES];
	branch_pkg::branch_entry_t e_next [`BR_ENTRIES];
	branch_pkg::branch_entry_t e_new;
	logic [`BR_CNT_WIDTH-1:0] count;
	logic [`BR_CNT_WIDTH-1:0] res_count;  // resolved entries, all at the front
	logic [`BR_CNT_WIDTH-1:0] target;
	logic head_synced;

	assign head_synced = e[0].gpr_tag == gpr_commit_tag && e[0].fpr_tag == fpr_commit_tag;
	assign commit = count != '0 && e[0].resolved && head_synced;
	assign flush = commit && e[0].failure;
	assign issue_ready = count < `BR_ENTRIES || commit;
	assign issue_fire = issue_valid && issue_ready;
	assign count_after_commit = count - `BR_CNT_WIDTH'(commit);
	assign speculating = count != '0;

	assign failure = e[0].failure;
	assign prediction_end = e[0].prediction;
	assign addr_on_failure_out = e[0].addr_on_failure;
	assign head_stack_pointer = e[0].stack_pointer;

	// oldest unresolved entry, after this cycle's shift
	assign target = res_count - `BR_CNT_WIDTH'(commit);

	always_comb begin
		e_new.resolved = 1'b0;
		e_new.failure = 1'b0;
		e_new.prediction = prediction;
		e_new.addr_on_failure = addr_on_failure;
		e_new.stack_pointer = stack_pointer;
		e_new.gpr_tag = gpr_issue_tag;
		e_new.fpr_tag = fpr_issue_tag;
	end

	always_comb begin
		logic [`BR_CNT_WIDTH-1:0] src;
		for (int i = 0; i < `BR_ENTRIES; i++) begin
			src = `BR_CNT_WIDTH'(i) + `BR_CNT_WIDTH'(commit);
			e_next[i] = (src < count) ? e[src[`BR_IDX_WIDTH-1:0]] : e_new;
			if (resolve && target == `BR_CNT_WIDTH'(i)) begin
				e_next[i].resolved = 1'b1;
				e_next[i].failure = taken != e_next[i].prediction[1];  // upper bit is the guess
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			count <= '0;
			res_count <= '0;
		end else begin
			count <= count - `BR_CNT_WIDTH'(commit) + `BR_CNT_WIDTH'(issue_fire);
			res_count <= res_count - `BR_CNT_WIDTH'(commit) + `BR_CNT_WIDTH'(resolve);
		end
	end

	always_ff @(posedge clk) begin
		e <= e_next;
	end

	// compare queue and branch queue must stay in step
	assert property (@(posedge clk) disable iff (reset)
		count <= `BR_ENTRIES && res_count <= count)
		else $error("branch count out of range");

endmodule

/* hw/branch_unit.sv */
`timescale 1ns/1ps
`include "branch_consts.svh"

module branch_unit (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input branch_pkg::cmp_type_t cmp_type,
	input operand_pkg::operand_t [1:0] gpr_opd,
	input operand_pkg::operand_t [1:0] fpr_opd,
	input logic [1:0] prediction,
	input logic [`ADDR_WIDTH-1:0] addr_on_failure,
	input logic [`ROB_WIDTH-1:0] gpr_issue_tag,
	input logic [`ROB_WIDTH-1:0] fpr_issue_tag,
	input logic gpr_cdb_valid,
	input logic [`ROB_WIDTH-1:0] gpr_cdb_tag,
	input logic [`DATA_WIDTH-1:0] gpr_cdb_data,
	input logic fpr_cdb_valid,
	input logic [`ROB_WIDTH-1:0] fpr_cdb_tag,
	input logic [`DATA_WIDTH-1:0] fpr_cdb_data,
	input logic [`ROB_WIDTH-1:0] gpr_commit_tag,
	input logic [`ROB_WIDTH-1:0] fpr_commit_tag,
	input logic call_valid,
	input logic [`ADDR_WIDTH-1:0] call_pc,
	input logic ret_valid,
	output logic issue_ready,
	output logic call_ready,
	output logic commit,
	output logic failure,
	output logic [1:0] prediction_end,
	output logic [`ADDR_WIDTH-1:0] addr_on_failure_out,
	output logic speculating,
	output logic [`ADDR_WIDTH-1:0] return_addr
);
	logic issue_fire;
	logic resolve;
	logic taken;
	logic flush;
	logic [`STACK_WIDTH-1:0] stack_pointer;
	logic [`STACK_WIDTH-1:0] head_stack_pointer;
	logic [`BR_CNT_WIDTH-1:0] count_after_commit;

	cmp_queue u_cmp_queue (
		.clk(clk), .reset(reset), .flush(flush), .issue_fire(issue_fire),
		.cmp_type(cmp_type), .gpr_opd(gpr_opd), .fpr_opd(fpr_opd),
		.gpr_cdb_valid(gpr_cdb_valid), .gpr_cdb_tag(gpr_cdb_tag), .gpr_cdb_data(gpr_cdb_data),
		.fpr_cdb_valid(fpr_cdb_valid), .fpr_cdb_tag(fpr_cdb_tag), .fpr_cdb_data(fpr_cdb_data),
		.resolve(resolve), .taken(taken)
	);

	branch_queue u_branch_queue (
		.clk(clk), .reset(reset), .issue_valid(issue_valid), .prediction(prediction),
		.addr_on_failure(addr_on_failure), .gpr_issue_tag(gpr_issue_tag),
		.fpr_issue_tag(fpr_issue_tag), .gpr_commit_tag(gpr_commit_tag),
		.fpr_commit_tag(fpr_commit_tag), .stack_pointer(stack_pointer),
		.resolve(resolve), .taken(taken), .issue_ready(issue_ready), .issue_fire(issue_fire),
		.commit(commit), .flush(flush), .failure(failure), .prediction_end(prediction_end),
		.addr_on_failure_out(addr_on_failure_out), .head_stack_pointer(head_stack_pointer),
		.count_after_commit(count_after_commit), .speculating(speculating)
	);

	return_stack u_return_stack (
		.clk(clk), .reset(reset), .call_valid(call_valid), .call_pc(call_pc),
		.ret_valid(ret_valid), .commit(commit), .flush(flush),
		.head_stack_pointer(head_stack_pointer), .count_after_commit(count_after_commit),
		.call_ready(call_ready), .stack_pointer(stack_pointer), .return_addr(return_addr)
	);

endmodule

/* hw/cmp_queue.sv */
`timescale 1ns/1ps
`include "branch_consts.svh"

module cmp_queue (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic issue_fire,
	input branch_pkg::cmp_type_t cmp_type,
	input operand_pkg::operand_t [1:0] gpr_opd,
	input operand_pkg::operand_t [1:0] fpr_opd,
	input logic gpr_cdb_valid,
	input logic [`ROB_WIDTH-1:0] gpr_cdb_tag,
	input logic [`DATA_WIDTH-1:0] gpr_cdb_data,
	input logic fpr_cdb_valid,
	input logic [`ROB_WIDTH-1:0] fpr_cdb_tag,
	input logic [`DATA_WIDTH-1:0] fpr_cdb_data,
	output logic resolve,
	output logic taken
);
	typedef struct packed {
		branch_pkg::cmp_type_t cmp_type;
		operand_pkg::operand_t [1:0] opd;
	} cmp_entry_t;

	logic [`BR_CNT_WIDTH-1:0] count;
	cmp_entry_t q [`BR_ENTRIES];
	cmp_entry_t q_upd [`BR_ENTRIES];
	cmp_entry_t q_next [`BR_ENTRIES];
	cmp_entry_t q_new;
	logic [`DATA_WIDTH-1:0] opd_a;
	logic [`DATA_WIDTH-1:0] opd_b;

	// sign-magnitude ordering, +0 and -0 compare equal
	function automatic logic float_le(logic [`DATA_WIDTH-1:0] x, logic [`DATA_WIDTH-1:0] y);
		logic x_zero;
		logic y_zero;
		x_zero = x[`DATA_WIDTH-2:0] == '0;
		y_zero = y[`DATA_WIDTH-2:0] == '0;
		if (x_zero && y_zero)
			return 1'b1;
		if (x[`DATA_WIDTH-1] != y[`DATA_WIDTH-1])
			return x[`DATA_WIDTH-1];
		if (x[`DATA_WIDTH-1])
			return x[`DATA_WIDTH-2:0] >= y[`DATA_WIDTH-2:0];
		return x[`DATA_WIDTH-2:0] <= y[`DATA_WIDTH-2:0];
	endfunction

	// incoming branch, may already catch its operand this cycle
	always_comb begin
		q_new.cmp_type = cmp_type;
		for (int j = 0; j < 2; j++) begin
			if (branch_pkg::is_int_cmp(cmp_type))
				q_new.opd[j] = operand_pkg::wakeup(gpr_opd[j], gpr_cdb_valid, gpr_cdb_tag,
					gpr_cdb_data);
			else
				q_new.opd[j] = operand_pkg::wakeup(fpr_opd[j], fpr_cdb_valid, fpr_cdb_tag,
					fpr_cdb_data);
		end
	end

	always_comb begin
		for (int i = 0; i < `BR_ENTRIES; i++) begin
			q_upd[i].cmp_type = q[i].cmp_type;
			for (int j = 0; j < 2; j++) begin
				if (branch_pkg::is_int_cmp(q[i].cmp_type))
					q_upd[i].opd[j] = operand_pkg::wakeup(q[i].opd[j], gpr_cdb_valid,
						gpr_cdb_tag, gpr_cdb_data);
				else
					q_upd[i].opd[j] = operand_pkg::wakeup(q[i].opd[j], fpr_cdb_valid,
						fpr_cdb_tag, fpr_cdb_data);
			end
		end
	end

	// fz only looks at operand zero
	assign resolve = count != '0 && q[0].opd[0].valid
		&& (q[0].cmp_type == branch_pkg::CMP_FZ || q[0].opd[1].valid);
	assign opd_a = q[0].opd[0].data;
	assign opd_b = q[0].opd[1].data;

	always_comb begin
		case (q[0].cmp_type)
			branch_pkg::CMP_E:   taken = opd_a == opd_b;
			branch_pkg::CMP_LE:  taken = $signed(opd_a) <= $signed(opd_b);
			branch_pkg::CMP_FLE: taken = float_le(opd_a, opd_b);
			default:             taken = opd_a[30:23] == '0;
		endcase
	end

	// shift out the head on resolve, free slots load the new entry
	always_comb begin
		logic [`BR_CNT_WIDTH-1:0] src;
		for (int i = 0; i < `BR_ENTRIES; i++) begin
			src = `BR_CNT_WIDTH'(i) + `BR_CNT_WIDTH'(resolve);
			q_next[i] = (src < count) ? q_upd[src[`BR_IDX_WIDTH-1:0]] : q_new;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || flush)
			count <= '0;
		else
			count <= count - `BR_CNT_WIDTH'(resolve) + `BR_CNT_WIDTH'(issue_fire);
	end

	always_ff @(posedge clk) begin
		q <= q_next;
	end

	// the branch queue holds issue back while every compare slot is busy
	assert property (@(posedge clk) disable iff (reset)
		issue_fire && count == `BR_ENTRIES |-> resolve)
		else $error("issue into a full compare queue");

endmodule

/* hw/operand_pkg.sv */
`include "branch_consts.svh"

package operand_pkg;

	// compare source, data is good once valid
	typedef struct packed {
		logic valid;
		logic [`ROB_WIDTH-1:0] tag;
		logic [`DATA_WIDTH-1:0] data;
	} operand_t;

	// grab a result bus beat for a waiting operand
	function automatic operand_t wakeup(
		operand_t opd,
		logic bus_valid,
		logic [`ROB_WIDTH-1:0] bus_tag,
		logic [`DATA_WIDTH-1:0] bus_data
	);
		operand_t res;
		res = opd;
		if (!opd.valid && bus_valid && bus_tag == opd.tag) begin
			res.valid = 1'b1;
			res.data = bus_data;
		end
		return res;
	endfunction

endpackage

/* hw/return_stack.sv */
`timescale 1ns/1ps
`include "branch_consts.svh"

module return_stack (
	input logic clk,
	input logic reset,
	input logic call_valid,
	input logic [`ADDR_WIDTH-1:0] call_pc,
	input logic ret_valid,
	input logic commit,
	input logic flush,
	input logic [`STACK_WIDTH-1:0] head_stack_pointer,
	input logic [`BR_CNT_WIDTH-1:0] count_after_commit,
	output logic call_ready,
	output logic [`STACK_WIDTH-1:0] stack_pointer,
	output logic [`ADDR_WIDTH-1:0] return_addr
);
	localparam int SLOTS = 2 ** `STACK_WIDTH;

	// overwritten slot, kept until its branches commit
	typedef struct packed {
		logic [`BR_CNT_WIDTH-1:0] depth;
		logic [`STACK_WIDTH-1:0] slot;
		logic [`ADDR_WIDTH-1:0] addr;
	} backup_t;

	logic [`ADDR_WIDTH-1:0] stack [SLOTS];
	logic [`ADDR_WIDTH-1:0] stack_next [SLOTS];
	logic [`STACK_WIDTH-1:0] sp_next;
	logic [`STACK_WIDTH-1:0] sp_up;
	backup_t bk [`BR_BACKUPS];
	backup_t bk_next [`BR_BACKUPS];
	backup_t bk_new;
	logic [`BK_CNT_WIDTH-1:0] bk_count;
	logic [`BK_CNT_WIDTH-1:0] n_drop;
	logic push;
	logic pop;
	logic save;

	assign sp_up = stack_pointer + 1'b1;

	// depths only grow toward the back, so drops are a prefix
	always_comb begin
		n_drop = '0;
		if (commit) begin
			for (int i = 0; i < `BR_BACKUPS; i++) begin
				if (`BK_CNT_WIDTH'(i) < bk_count && bk[i].depth == `BR_CNT_WIDTH'(1))
					n_drop = n_drop + 1'b1;
			end
		end
	end

	assign call_ready = !(count_after_commit != '0 && bk_count == `BR_BACKUPS && n_drop == '0);
	assign push = call_valid && call_ready;
	assign pop = ret_valid && !push;
	assign save = push && count_after_commit != '0 && !flush;

	assign bk_new.depth = count_after_commit;
	assign bk_new.slot = sp_up;
	assign bk_new.addr = stack[sp_up];

	always_comb begin
		logic [`BK_CNT_WIDTH-1:0] src;
		for (int i = 0; i < `BR_BACKUPS; i++) begin
			src = `BK_CNT_WIDTH'(i) + n_drop;
			bk_next[i] = bk_new;
			if (src < bk_count) begin
				bk_next[i] = bk[src[`BK_IDX_WIDTH-1:0]];
				if (commit)
					bk_next[i].depth = bk_next[i].depth - 1'b1;
			end
		end
	end

	always_comb begin
		stack_next = stack;
		if (flush) begin
			// youngest first so the oldest copy of a slot wins
			for (int i = `BR_BACKUPS - 1; i >= 0; i--) begin
				if (`BK_CNT_WIDTH'(i) < bk_count)
					stack_next[bk[i].slot] = bk[i].addr;
			end
		end else if (push) begin
			stack_next[sp_up] = call_pc;
		end
	end

	always_comb begin
		if (flush)
			sp_next = head_stack_pointer;
		else if (push)
			sp_next = sp_up;
		else if (pop)
			sp_next = stack_pointer - 1'b1;
		else
			sp_next = stack_pointer;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			stack_pointer <= '1;  // top slot
			bk_count <= '0;
		end else begin
			stack_pointer <= sp_next;
			bk_count <= flush ? '0 : bk_count - n_drop + `BK_CNT_WIDTH'(save);
		end
	end

	always_ff @(posedge clk) begin
		stack <= stack_next;
		bk <= bk_next;
		return_addr <= stack_next[sp_next];
	end

	// oldest backup still belongs to a branch in flight
	assert property (@(posedge clk) disable iff (reset)
		bk_count != '0 |-> bk[0].depth != '0
			&& bk[0].depth <= count_after_commit + `BR_CNT_WIDTH'(commit))
		else $error("backup depth outside the branches in flight");

endmodule

/* tb.f */
+incdir+hw
hw/operand_pkg.sv
hw/branch_pkg.sv
hw/cmp_queue.sv
hw/branch_queue.sv
hw/return_stack.sv
hw/branch_unit.sv
verif/branch_unit_tb.sv

/* verif/branch_unit_tb.sv */
`timescale 1ns/1ps
`include "branch_consts.svh"

module branch_unit_tb;
	localparam logic [`ROB_WIDTH-1:0] LATE_TAG = 5'd9;
	localparam logic [`ROB_WIDTH-1:0] HOLD_TAG = 5'd31;  // never matches an issue tag

	logic clk = 1'b0;
	logic reset;
	logic issue_valid;
	branch_pkg::cmp_type_t cmp_type;
	operand_pkg::operand_t [1:0] gpr_opd;
	operand_pkg::operand_t [1:0] fpr_opd;
	logic [1:0] prediction;
	logic [`ADDR_WIDTH-1:0] addr_on_failure;
	logic [`ROB_WIDTH-1:0] gpr_issue_tag;
	logic [`ROB_WIDTH-1:0] fpr_issue_tag;
	logic gpr_cdb_valid;
	logic [`ROB_WIDTH-1:0] gpr_cdb_tag;
	logic [`DATA_WIDTH-1:0] gpr_cdb_data;
	logic fpr_cdb_valid;
	logic [`ROB_WIDTH-1:0] fpr_cdb_tag;
	logic [`DATA_WIDTH-1:0] fpr_cdb_data;
	logic [`ROB_WIDTH-1:0] gpr_commit_tag;
	logic [`ROB_WIDTH-1:0] fpr_commit_tag;
	logic call_valid;
	logic [`ADDR_WIDTH-1:0] call_pc;
	logic ret_valid;
	logic issue_ready;
	logic call_ready;
	logic commit;
	logic failure;
	logic [1:0] prediction_end;
	logic [`ADDR_WIDTH-1:0] addr_on_failure_out;
	logic speculating;
	logic [`ADDR_WIDTH-1:0] return_addr;

	logic [31:0] lcg_state = 32'd52926;
	logic [18:0] model_q [$];  // {fail, prediction, addr}, oldest first
	logic [18:0] pend_entry;
	logic exp_fail;
	logic [1:0] exp_pred;
	logic [`ADDR_WIDTH-1:0] exp_addr;
	logic [`ADDR_WIDTH-1:0] exp_ret;
	logic late_pending;
	logic ras_check;
	int outstanding = 0;
	int issued = 0;
	int commits = 0;
	int errors = 0;
	int cycles = 0;
	int test_num;
	int test_errors;

	branch_unit dut0 (.*);

	always #4 clk = ~clk;

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic branch_pkg::cmp_type_t random_type();
		logic [31:0] r;
		r = next_random();
		return branch_pkg::cmp_type_t'(r[31:30]);
	endfunction

	// float order through a signed key, so -0 lands on +0
	function automatic logic expect_taken(branch_pkg::cmp_type_t t, logic [31:0] a,
		logic [31:0] b);
		logic signed [32:0] ka;
		logic signed [32:0] kb;
		ka = {2'b00, a[30:0]};
		kb = {2'b00, b[30:0]};
		if (a[31])
			ka = -ka;
		if (b[31])
			kb = -kb;
		case (t)
			branch_pkg::CMP_FZ: return a[30:23] == 8'd0;
			branch_pkg::CMP_FLE: return ka <= kb;
			branch_pkg::CMP_E: return a == b;
			default: return $signed(a) <= $signed(b);
		endcase
	endfunction

	// model of branches in flight, a failed commit drops everything younger
	always @(posedge clk) begin
		if (!reset) begin
			if (commit) begin
				if (model_q.size() != 0)
					void'(model_q.pop_front());
				commits++;
			end
			if (issue_valid && issue_ready) begin
				model_q.push_back(pend_entry);
				issued++;
			end
			if (commit && failure)
				model_q.delete();
		end
		outstanding <= model_q.size();
		if (model_q.size() != 0)
			{exp_fail, exp_pred, exp_addr} <= model_q[0];
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > 40 * issued + 200) begin
			$display("timeout: run stalled after %0d cycles", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	assert property (@(posedge clk) $fell(reset) |->
		issue_ready && call_ready && !commit && !speculating)
		else begin $display("outputs not idle after reset"); errors++; end
	assert property (@(posedge clk) disable iff (reset) commit |-> outstanding != 0)
		else begin $display("commit with no branch outstanding"); errors++; end
	assert property (@(posedge clk) disable iff (reset) commit |-> prediction_end == exp_pred)
		else begin
			$display("Mismatch prediction_end: got 0x%h expected 0x%h",
				$sampled(prediction_end), $sampled(exp_pred));
			errors++;
		end
	assert property (@(posedge clk) disable iff (reset) commit |-> failure == exp_fail)
		else begin
			$display("Mismatch failure: got 0x%h expected 0x%h", $sampled(failure),
				$sampled(exp_fail));
			errors++;
		end
	assert property (@(posedge clk) disable iff (reset)
		commit |-> addr_on_failure_out == exp_addr)
		else begin
			$display("Mismatch addr_on_failure_out: got 0x%h expected 0x%h",
				$sampled(addr_on_failure_out), $sampled(exp_addr));
			errors++;
		end
	assert property (@(posedge clk) disable iff (reset) commit && failure |=> !speculating)
		else begin $display("still speculating after a failed commit"); errors++; end
	assert property (@(posedge clk) disable iff (reset)
		outstanding == `BR_ENTRIES && !commit |-> !issue_ready)
		else begin $display("issue_ready high with the branch queue full"); errors++; end
	assert property (@(posedge clk) disable iff (reset) late_pending |-> !commit)
		else begin $display("branch committed before its late operand"); errors++; end
	assert property (@(posedge clk) disable iff (reset) call_valid |-> call_ready)
		else begin $display("call refused with backups free"); errors++; end
	assert property (@(posedge clk) disable iff (reset) ras_check |-> return_addr == exp_ret)
		else begin
			$display("Mismatch return_addr: got 0x%h expected 0x%h", $sampled(return_addr),
				$sampled(exp_ret));
			errors++;
		end

	// called on a falling edge, returns on one
	task automatic issue_branch(input branch_pkg::cmp_type_t t, input logic late,
		input logic guess_right);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic tk;
		int start;
		r = next_random();
		a = next_random();
		b = next_random();
		case (t)
			branch_pkg::CMP_FZ: if (r[20]) a[30:23] = 8'd0;
			branch_pkg::CMP_FLE: begin
				if (r[20]) begin
					a = {r[21], 31'd0};  // signed zeros
					b = {!r[21], 31'd0};
				end else if (r[22]) begin
					b[31] = a[31];
				end
			end
			default: if (r[20]) b = a;
		endcase
		tk = expect_taken(t, a, b);
		prediction = {guess_right ? tk : !tk, r[13]};
		addr_on_failure = r[31:16];
		pend_entry = {!guess_right, prediction, addr_on_failure};
		cmp_type = t;
		gpr_opd[0] = {!late, LATE_TAG, late ? ~a : a};  // stale data if late
		gpr_opd[1] = {1'b1, 5'd0, b};
		fpr_opd = gpr_opd;
		issue_valid = 1'b1;
		late_pending = late;
		start = issued;
		do @(negedge clk); while (issued == start);
		issue_valid = 1'b0;
		if (late) begin
			repeat (4) @(negedge clk);
			late_pending = 1'b0;
			if (t == branch_pkg::CMP_E || t == branch_pkg::CMP_LE) begin
				gpr_cdb_valid = 1'b1;
				gpr_cdb_tag = LATE_TAG;
				gpr_cdb_data = a;
			end else begin
				fpr_cdb_valid = 1'b1;
				fpr_cdb_tag = LATE_TAG;
				fpr_cdb_data = a;
			end
			@(negedge clk);
			gpr_cdb_valid = 1'b0;
			fpr_cdb_valid = 1'b0;
		end
	endtask

	task automatic hold_tags(input logic on);
		gpr_commit_tag = on ? HOLD_TAG : 5'd0;
		fpr_commit_tag = on ? HOLD_TAG : 5'd0;
	endtask

	task automatic drain();
		while (model_q.size() != 0)
			@(negedge clk);
		repeat (2) @(negedge clk);
	endtask

	task automatic do_call(input logic [`ADDR_WIDTH-1:0] pc);
		call_valid = 1'b1;
		call_pc = pc;
		ras_check = 1'b0;
		@(negedge clk);
		call_valid = 1'b0;
		exp_ret = pc;
		ras_check = 1'b1;
	endtask

	task automatic do_return(input logic [`ADDR_WIDTH-1:0] expected);
		ret_valid = 1'b1;
		ras_check = 1'b0;
		@(negedge clk);
		ret_valid = 1'b0;
		exp_ret = expected;
		ras_check = 1'b1;
	endtask

	task automatic finish_test(input string name);
		if (errors == test_errors)
			$display("test %0d %s: ok", test_num, name);
		else
			$display("test %0d %s: %0d errors", test_num, name, errors - test_errors);
		test_num++;
		test_errors = errors;
	endtask

	initial begin
		int start;
		reset = 1'b1;
		issue_valid = 1'b0;
		cmp_type = branch_pkg::CMP_E;
		gpr_opd = '0;
		fpr_opd = '0;
		prediction = 2'd0;
		addr_on_failure = '0;
		gpr_issue_tag = '0;
		fpr_issue_tag = '0;
		gpr_cdb_valid = 1'b0;
		gpr_cdb_tag = '0;
		gpr_cdb_data = '0;
		fpr_cdb_valid = 1'b0;
		fpr_cdb_tag = '0;
		fpr_cdb_data = '0;
		hold_tags(1'b0);
		call_valid = 1'b0;
		call_pc = '0;
		ret_valid = 1'b0;
		late_pending = 1'b0;
		ras_check = 1'b0;
		exp_ret = '0;
		pend_entry = '0;
		test_num = 1;
		test_errors = 0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		for (int i = 0; i < 8; i++)
			issue_branch(branch_pkg::cmp_type_t'(2'(i)), 1'b0, 1'b1);
		drain();
		finish_test("compare types");

		// younger ones sit behind the failing head
		hold_tags(1'b1);
		issue_branch(branch_pkg::CMP_E, 1'b0, 1'b0);
		issue_branch(branch_pkg::CMP_LE, 1'b0, 1'b1);
		issue_branch(branch_pkg::CMP_FZ, 1'b0, 1'b1);
		hold_tags(1'b0);
		drain();
		finish_test("wrong prediction");

		issue_branch(branch_pkg::CMP_LE, 1'b1, 1'b1);
		drain();
		issue_branch(branch_pkg::CMP_FLE, 1'b1, 1'b0);
		drain();
		finish_test("late operands");

		hold_tags(1'b1);
		for (int i = 0; i < `BR_ENTRIES; i++)
			issue_branch(random_type(), 1'b0, 1'b1);
		fork
			issue_branch(branch_pkg::CMP_E, 1'b0, 1'b1);
			begin
				repeat (6) @(negedge clk);
				hold_tags(1'b0);
			end
		join
		drain();
		finish_test("back-pressure");

		do_call(16'h1230);
		do_call(16'h4560);
		do_return(16'h1230);
		finish_test("calls and returns");

		// top is 0x5670 when the branch issues, then a return and a call replace it
		do_call(16'h5670);
		hold_tags(1'b1);
		issue_branch(branch_pkg::CMP_E, 1'b0, 1'b0);
		do_return(16'h1230);
		do_call(16'h7890);  // overwrites a live slot
		ras_check = 1'b0;
		exp_ret = 16'h5670;
		start = commits;
		hold_tags(1'b0);
		while (commits == start)
			@(negedge clk);
		ras_check = 1'b1;
		drain();
		finish_test("speculative call");

		$display("tests %0d, branches %0d, commits %0d, errors %0d", test_num - 1, issued,
			commits, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule
